//--- src.f
+incdir+rtl
rtl/pipe_pkg.sv
rtl/rob_pkg.sv
rtl/branch_recovery_seq.sv
rtl/front_stomp.sv
rtl/rob_store.sv
rtl/rob_stomp.sv
rtl/stomp_top.sv
bench/stomp_properties.sv
bench/stomp_tb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --timing --assert --timescale 1ns/1ps
TOP        = stomp_tb
FILELIST   = src.f
PASS_TEXT  = === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf obj_dir

//--- bench/stomp_tb.sv
// Stomp control testbench

`include "stomp_settings.svh"

module stomp_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_FIXED = 4;
	localparam int NUM_CASES = 16;
	localparam int CYCLE_LIMIT = NUM_CASES * 20 + 200;
	localparam logic [31:0] TARGET = 32'h0000_2000;
	localparam logic [31:0] OTHER = 32'h0000_0300;

	// one ROB scenario, entries packed from index 7 down to 0
	typedef struct packed {
		logic [7:0][3:0] grp;
		logic [7:0][4:0] bno;
		logic [7:0]      br;
		logic [7:0]      cjb;
		logic [2:0]      missid;
		logic [2:0]      dest;
		logic            found;
		logic            fcu_idv;
		logic [2:0]      fcu_id;
		logic            takb;
		logic [4:0]      stomp_bno;
		logic [7:0]      exp_mask;
	} rob_case_t;

	// one front end step, depth counts the stages that already hold the target
	typedef struct packed {
		logic [2:0] depth;
		logic       adv;
		logic [3:0] flags;
	} front_step_t;

	logic clk = 1'b0;
	logic rst;
	logic advance_pipeline;
	logic advance_seg2;
	pipe_pkg::pc_address_ex_t pc, pc_f, pc_fet, pc_mux, pc_dec, misspc;
	logic branchmiss;
	rob_pkg::rob_ndx_t missid, destination_rndx, fcu_id;
	logic found_destination;
	logic do_bsr;
	logic fcu_idv;
	logic takb;
	logic [4:0] stomp_bno;
	rob_pkg::rob_write_t dispatch;
	logic stomp_fet, stomp_mux, stomp_dec, stomp_ren, stomp_que, stomp_quem;
	logic [`ROB_ENTRIES-1:0] robentry_stomp;
	pipe_pkg::branch_state_t branch_state;

	rob_case_t cases [NUM_CASES];
	front_step_t steps [10];
	integer seed = 87;
	int cycles = 0;

	stomp_top uut (.*);

	always #50 clk = ~clk;

	// ========================================================================
	// timeout and checking
	// ========================================================================

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("=== FAIL ===");
			$fatal(1, "timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
			$display("=== FAIL ===");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic pipe_pkg::pc_address_ex_t make_addr(input logic [31:0] a);
		pipe_pkg::pc_address_ex_t r;
		r = '0;
		r.pc = a;
		return r;
	endfunction

	// ========================================================================
	// reference model of the ROB stomp rules
	// ========================================================================

	// entry i of the case gets serial number base + i when it is dispatched
	function automatic logic [7:0] model_stomp(input rob_case_t c, input logic [7:0] base);
		logic [7:0] m;
		logic exempt;
		logic [7:0] sn_n;
		m = '0;
		if (`SUPPORT_BACKOUT != 0)
			exempt = c.fcu_idv && (c.br[c.fcu_id] || c.cjb[c.fcu_id]);
		else
			exempt = c.fcu_idv && c.br[c.fcu_id] && !c.takb;
		for (int n = 0; n < 8; n++) begin
			sn_n = base + 8'(n);
			if (c.found)
				m[n] = sn_n > base + 8'(c.missid) && sn_n < base + 8'(c.dest);
			else
				m[n] = c.fcu_idv && sn_n > base + 8'(c.missid) && c.bno[n] != c.stomp_bno;
			if (exempt && c.grp[n] == c.grp[c.fcu_id] && sn_n > base + 8'(c.fcu_id))
				m[n] = 1'b0;
		end
		return m;
	endfunction

	task automatic build_tables();
		// miss between entries 1 and 5 with the destination found
		cases[0] = '0;
		cases[0].missid = 3'd1;
		cases[0].dest = 3'd5;
		cases[0].found = 1'b1;
		cases[0].exp_mask = 8'h1c;
		// unresolved miss at entry 2, younger entries off path 3 are stomped
		cases[1] = '0;
		cases[1].grp = 32'h2221_1122;
		cases[1].bno = {5'd4, 5'd3, 5'd4, 5'd4, 5'd4, 5'd3, 5'd4, 5'd4};
		cases[1].missid = 3'd2;
		cases[1].fcu_idv = 1'b1;
		cases[1].fcu_id = 3'd2;
		cases[1].stomp_bno = 5'd3;
		cases[1].exp_mask = 8'hb8;
		// entry 2 is a not taken branch, its group members 3 and 4 survive
		cases[2] = cases[1];
		cases[2].br = 8'h04;
		cases[2].exp_mask = 8'ha0;
		// no valid branch unit result, nothing is stomped
		cases[3] = cases[1];
		cases[3].fcu_idv = 1'b0;
		cases[3].exp_mask = 8'h00;
		for (int k = NUM_FIXED; k < NUM_CASES; k++) begin
			for (int i = 0; i < 8; i++) begin
				cases[k].grp[i] = 4'($random(seed) & 3);
				cases[k].bno[i] = 5'($random(seed) & 3);
			end
			cases[k].br = 8'($random(seed));
			cases[k].cjb = 8'($random(seed));
			cases[k].missid = 3'($random(seed));
			cases[k].dest = 3'($random(seed));
			cases[k].found = 1'($random(seed));
			cases[k].fcu_idv = 1'($random(seed));
			cases[k].fcu_id = 3'($random(seed));
			cases[k].takb = 1'($random(seed));
			cases[k].stomp_bno = 5'($random(seed) & 3);
			cases[k].exp_mask = model_stomp(cases[k], 8'(k * 8));
		end
		// the target walks down one stage per advance, with a hold after each
		for (int s = 0; s < 5; s++) begin
			steps[2*s].depth = 3'(s + 1);
			steps[2*s].adv = 1'b1;
			steps[2*s].flags = 4'b1111 >> s;
			steps[2*s+1] = steps[2*s];
			steps[2*s+1].adv = 1'b0;
		end
	endtask

	// ========================================================================
	// scenarios
	// ========================================================================

	task automatic front_flush();
		logic [3:0] got;
		// fill the front end with the reset address to drop the reset stomps
		@(posedge clk);
		pc <= make_addr(`RESET_PC);
		pc_f <= make_addr(`RESET_PC);
		pc_fet <= make_addr(`RESET_PC);
		pc_mux <= make_addr(`RESET_PC);
		pc_dec <= make_addr(`RESET_PC);
		advance_pipeline <= 1'b1;
		advance_seg2 <= 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check("stage stomps after fill",
			32'({stomp_fet, stomp_mux, stomp_dec, stomp_ren, stomp_que, stomp_quem}), 32'h0);
		@(posedge clk);
		pc <= make_addr(OTHER);
		pc_f <= make_addr(OTHER);
		pc_fet <= make_addr(OTHER);
		pc_mux <= make_addr(OTHER);
		pc_dec <= make_addr(OTHER);
		misspc <= make_addr(TARGET);
		branchmiss <= 1'b1;
		@(negedge clk);
		check("stage stomps on edge",
			32'({stomp_fet, stomp_mux, stomp_dec, stomp_ren, stomp_que, stomp_quem}), 32'h3f);
		for (int r = 0; r < 10; r++) begin
			@(posedge clk);
			branchmiss <= 1'b0;
			pc <= make_addr(steps[r].depth >= 1 ? TARGET : OTHER);
			pc_f <= make_addr(steps[r].depth >= 2 ? TARGET : OTHER);
			pc_fet <= make_addr(steps[r].depth >= 3 ? TARGET : OTHER);
			pc_mux <= make_addr(steps[r].depth >= 4 ? TARGET : OTHER);
			pc_dec <= make_addr(steps[r].depth >= 5 ? TARGET : OTHER);
			advance_pipeline <= steps[r].adv;
			advance_seg2 <= steps[r].adv;
			@(posedge clk);
			advance_pipeline <= 1'b0;
			advance_seg2 <= 1'b0;
			@(negedge clk);
			got = {stomp_fet, stomp_mux, stomp_dec, stomp_ren};
			check("stomp_fet/mux/dec/ren", 32'(got), 32'(steps[r].flags));
		end
	endtask

	task automatic recovery_walk();
		pipe_pkg::branch_state_t walk [5];
		walk = '{pipe_pkg::BS_CHKPT_RESTORE, pipe_pkg::BS_STATE1, pipe_pkg::BS_DONE1,
			pipe_pkg::BS_DONE2, pipe_pkg::BS_IDLE};
		while (branch_state != pipe_pkg::BS_IDLE)
			@(posedge clk);
		@(posedge clk);
		branchmiss <= 1'b1;
		found_destination <= 1'b0;
		@(posedge clk);
		branchmiss <= 1'b0;
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			check("branch_state", 32'(branch_state), 32'(walk[i]));
		end
	endtask

	task automatic run_rob_case(input rob_case_t c);
		rob_pkg::rob_write_t w;
		while (branch_state != pipe_pkg::BS_IDLE)
			@(posedge clk);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			w = '0;
			w.wr = 1'b1;
			w.ndx = 3'(i);
			w.entry.valid = 1'b1;
			w.entry.grp = c.grp[i];
			w.entry.bno_t = c.bno[i];
			w.entry.br = c.br[i];
			w.entry.cjb = c.cjb[i];
			dispatch <= w;
		end
		@(posedge clk);
		dispatch.wr <= 1'b0;
		@(posedge clk);
		branchmiss <= 1'b1;
		missid <= c.missid;
		destination_rndx <= c.dest;
		found_destination <= c.found;
		fcu_idv <= c.fcu_idv;
		fcu_id <= c.fcu_id;
		takb <= c.takb;
		stomp_bno <= c.stomp_bno;
		@(posedge clk);
		branchmiss <= 1'b0;
		found_destination <= 1'b0;
		fcu_idv <= 1'b0;
		@(negedge clk);
		check("robentry_stomp", 32'(robentry_stomp), 32'(c.exp_mask));
	endtask

	initial begin
		rst = 1'b1;
		advance_pipeline = 1'b0;
		advance_seg2 = 1'b0;
		pc = '0;
		pc_f = '0;
		pc_fet = '0;
		pc_mux = '0;
		pc_dec = '0;
		misspc = '0;
		branchmiss = 1'b0;
		missid = '0;
		destination_rndx = '0;
		found_destination = 1'b0;
		do_bsr = 1'b0;
		fcu_idv = 1'b0;
		fcu_id = '0;
		takb = 1'b0;
		stomp_bno = '0;
		dispatch = '0;
		build_tables();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("robentry_stomp", 32'(robentry_stomp), 32'h0);
		check("branch_state", 32'(branch_state), 32'(pipe_pkg::BS_IDLE));
		// every stage starts out stomped until the reset address has filled it
		check("stage stomps after reset",
			32'({stomp_fet, stomp_mux, stomp_dec, stomp_ren, stomp_que, stomp_quem}), 32'h3f);
		front_flush();
		recovery_walk();
		for (int k = 0; k < NUM_CASES; k++)
			run_rob_case(cases[k]);
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- bench/stomp_properties.sv
// Stomp control assertions

`include "stomp_settings.svh"

module stomp_properties (
	input logic                                   clk,
	input logic                                   rst,
	input rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob,
	input logic [`ROB_ENTRIES-1:0]                robentry_stomp,
	input pipe_pkg::branch_state_t                branch_state,
	input logic                                   pe_stomp,
	input logic                                   stomp_quem
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [`ROB_ENTRIES-1:0] valid;
	logic busy;

	always_comb begin
		for (int i = 0; i < `ROB_ENTRIES; i++)
			valid[i] = rob[i].valid;
	end

	assign busy = (branch_state != pipe_pkg::BS_IDLE);

	// entries never go invalid outside reset, so the registered bitmap can be
	// held against the current valid bits
	a_valid_only: assert property (@(posedge clk) disable iff (rst)
		(robentry_stomp & ~valid) == '0)
		else $error("robentry_stomp marks an empty ROB entry");

	// the recovery walk takes four busy cycles, a fifth one means it is stuck
	a_recovery_ends: assert property (@(posedge clk) disable iff (rst)
		!(busy && $past(busy, 1) && $past(busy, 2) && $past(busy, 3) && $past(busy, 4)))
		else $error("branch_state did not return to idle within five cycles");

	a_quem_follows_edge: assert property (@(posedge clk) disable iff (rst)
		pe_stomp |=> stomp_quem)
		else $error("stomp_quem low in the cycle after a stomp edge");

endmodule

bind stomp_top stomp_properties u_props (
	.clk            (clk),
	.rst            (rst),
	.rob            (rob),
	.robentry_stomp (robentry_stomp),
	.branch_state   (branch_state),
	.pe_stomp       (u_front.pe_stomp),
	.stomp_quem     (stomp_quem)
);

//--- rtl/stomp_top.sv
// Stomp control top level

`include "stomp_settings.svh"

module stomp_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     advance_pipeline,
	input  logic                     advance_seg2,
	input  pipe_pkg::pc_address_ex_t pc,
	input  pipe_pkg::pc_address_ex_t pc_f,
	input  pipe_pkg::pc_address_ex_t pc_fet,
	input  pipe_pkg::pc_address_ex_t pc_mux,
	input  pipe_pkg::pc_address_ex_t pc_dec,
	input  logic                     branchmiss,
	input  pipe_pkg::pc_address_ex_t misspc,
	input  rob_pkg::rob_ndx_t        missid,
	input  logic                     found_destination,
	input  rob_pkg::rob_ndx_t        destination_rndx,
	input  logic                     do_bsr,
	input  logic                     fcu_idv,
	input  rob_pkg::rob_ndx_t        fcu_id,
	input  logic                     takb,
	input  logic [4:0]               stomp_bno,
	input  rob_pkg::rob_write_t      dispatch,
	output logic                     stomp_fet,
	output logic                     stomp_mux,
	output logic                     stomp_dec,
	output logic                     stomp_ren,
	output logic                     stomp_que,
	output logic                     stomp_quem,
	output logic [`ROB_ENTRIES-1:0]  robentry_stomp,
	output pipe_pkg::branch_state_t  branch_state
);

	// whole entry array, read by the stomp rules
	rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob;

	// ========================================================================
	// recovery sequencer and front end
	// ========================================================================

	branch_recovery_seq u_seq (
		.clk               (clk),
		.rst               (rst),
		.branchmiss        (branchmiss),
		.found_destination (found_destination),
		.branch_state      (branch_state)
	);

	front_stomp u_front (
		.clk               (clk),
		.rst               (rst),
		.advance_pipeline  (advance_pipeline),
		.advance_seg2      (advance_seg2),
		.do_bsr            (do_bsr),
		.branchmiss        (branchmiss),
		.found_destination (found_destination),
		.branch_state      (branch_state),
		.misspc            (misspc),
		.pc                (pc),
		.pc_f              (pc_f),
		.pc_fet            (pc_fet),
		.pc_mux            (pc_mux),
		.pc_dec            (pc_dec),
		.stomp_fet         (stomp_fet),
		.stomp_mux         (stomp_mux),
		.stomp_dec         (stomp_dec),
		.stomp_ren         (stomp_ren),
		.stomp_que         (stomp_que),
		.stomp_quem        (stomp_quem)
	);

	// ========================================================================
	// reorder buffer
	// ========================================================================

	rob_store u_store (
		.clk      (clk),
		.rst      (rst),
		.dispatch (dispatch),
		.rob      (rob)
	);

	rob_stomp u_rstomp (
		.clk               (clk),
		.rst               (rst),
		.rob               (rob),
		.branchmiss        (branchmiss),
		.found_destination (found_destination),
		.fcu_idv           (fcu_idv),
		.takb              (takb),
		.destination_rndx  (destination_rndx),
		.missid            (missid),
		.fcu_id            (fcu_id),
		.stomp_bno         (stomp_bno),
		.branch_state      (branch_state),
		.robentry_stomp    (robentry_stomp)
	);

endmodule

//--- rtl/rob_stomp.sv
// ROB stomp bitmap

`include "stomp_settings.svh"

module rob_stomp (
	input  logic                                   clk,
	input  logic                                   rst,
	input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob,
	input  logic                                   branchmiss,
	input  logic                                   found_destination,
	input  logic                                   fcu_idv,
	input  logic                                   takb,
	input  rob_pkg::rob_ndx_t                      destination_rndx,
	input  rob_pkg::rob_ndx_t                      missid,
	input  rob_pkg::rob_ndx_t                      fcu_id,
	input  logic [4:0]                             stomp_bno,
	input  pipe_pkg::branch_state_t                branch_state,
	output logic [`ROB_ENTRIES-1:0]                robentry_stomp
);

	localparam bit BACKOUT = (`SUPPORT_BACKOUT != 0);

	logic [`ROB_ENTRIES-1:0] stomp_next;
	logic recovering;
	logic exempt_grp;

	// a miss is pending or the sequencer has not yet reached DONE2
	always_comb begin
		recovering = branchmiss ||
			(branch_state != pipe_pkg::BS_IDLE && branch_state < pipe_pkg::BS_DONE2);
	end

	// with backout the younger members of a branch group become copy targets,
	// so they must survive whether the branch was taken or not
	always_comb begin
		if (BACKOUT)
			exempt_grp = fcu_idv && (rob[fcu_id].br || rob[fcu_id].cjb);
		else
			exempt_grp = fcu_idv && rob[fcu_id].br && !takb;
	end

	// ========================================================================
	// per entry rules
	// ========================================================================

	always_comb begin
		for (int n = 0; n < `ROB_ENTRIES; n++) begin
			stomp_next[n] = 1'b0;
			if (found_destination) begin
				// the work between the branch and its target is wrong path
				if (rob[n].sn > rob[missid].sn && rob[n].sn < rob[destination_rndx].sn)
					stomp_next[n] = 1'b1;
			end else if (recovering && fcu_idv && rob[n].sn > rob[missid].sn &&
				rob[n].bno_t != stomp_bno) begin
				stomp_next[n] = 1'b1;
			end
			if (exempt_grp && rob[n].grp == rob[fcu_id].grp && rob[n].sn > rob[fcu_id].sn)
				stomp_next[n] = 1'b0;
			// an empty slot is never reported
			if (!rob[n].valid)
				stomp_next[n] = 1'b0;
		end
	end

	// the bitmap fans out widely, so it leaves the block from a register
	always_ff @(posedge clk) begin
		if (rst)
			robentry_stomp <= '0;
		else
			robentry_stomp <= stomp_next;
	end

endmodule

//--- rtl/rob_store.sv
// Reorder buffer entry store

`include "stomp_settings.svh"

module rob_store (
	input  logic                                      clk,
	input  logic                                      rst,
	input  rob_pkg::rob_write_t                       dispatch,
	output rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]    rob
);

	logic [`SN_BITS-1:0] sn_ctr;
	rob_pkg::rob_entry_t wr_entry;

	// ========================================================================
	// serial number assignment
	// ========================================================================

	// every dispatch gets the next number, so a plain compare of two sn
	// fields tells which entry was dispatched first
	always_comb begin
		wr_entry = dispatch.entry;
		wr_entry.sn = sn_ctr;
	end

	always_ff @(posedge clk) begin
		if (rst)
			sn_ctr <= '0;
		else if (dispatch.wr)
			sn_ctr <= sn_ctr + 1'b1;
	end

	// ========================================================================
	// entry array
	// ========================================================================

	// only the valid bits are cleared, the payload of an invalid entry is
	// never looked at
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ROB_ENTRIES; i++)
				rob[i].valid <= 1'b0;
		end else if (dispatch.wr) begin
			rob[dispatch.ndx] <= wr_entry;
		end
	end

endmodule

//--- rtl/front_stomp.sv
// Front end flush waterfall

`include "stomp_settings.svh"

module front_stomp (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      advance_pipeline,
	input  logic                      advance_seg2,
	input  logic                      do_bsr,
	input  logic                      branchmiss,
	input  logic                      found_destination,
	input  pipe_pkg::branch_state_t   branch_state,
	input  pipe_pkg::pc_address_ex_t  misspc,
	input  pipe_pkg::pc_address_ex_t  pc,
	input  pipe_pkg::pc_address_ex_t  pc_f,
	input  pipe_pkg::pc_address_ex_t  pc_fet,
	input  pipe_pkg::pc_address_ex_t  pc_mux,
	input  pipe_pkg::pc_address_ex_t  pc_dec,
	output logic                      stomp_fet,
	output logic                      stomp_mux,
	output logic                      stomp_dec,
	output logic                      stomp_ren,
	output logic                      stomp_que,
	output logic                      stomp_quem
);

	logic stomp_pipeline;
	logic stomp_pipeline_r;
	logic pe_stomp;
	logic step1;
	logic step2;
	logic bsr_stomp;
	logic stomp_aln;
	pipe_pkg::pc_address_ex_t misspcr [5];

	// registered stage flags, the outputs add the edge pulse on top
	logic aln_r;
	logic fet_r;
	logic mux_r;
	logic dec_r;
	logic ren_r;
	logic que_r;
	logic que2_r;
	logic quem_r;

	// do_bsr travels beside the fetch group it belongs to
	logic bsr_mux;
	logic bsr_dec;
	logic bsr_ren;
	logic bsr_que;

	// a stage is set by the edge pulse, released when the target address has
	// reached the stage before it, and otherwise takes over its predecessor
	function automatic logic next_flag(input logic pulse, input logic hit, input logic prev);
		next_flag = pulse ? 1'b1 : (hit ? 1'b0 : prev);
	endfunction

	// ========================================================================
	// stomp condition and its rising edge
	// ========================================================================

	// the front end is flushed while a miss is unresolved or while the
	// recovery sequencer is walking its states
	always_comb begin
		stomp_pipeline = (branchmiss && !found_destination) ||
			(branch_state >= pipe_pkg::BS_CHKPT_RESTORE &&
			 branch_state <= pipe_pkg::BS_DONE2);
	end

	// the edge is only taken on a cycle where the pipeline moves
	always_ff @(posedge clk) begin
		if (rst)
			stomp_pipeline_r <= 1'b0;
		else if (advance_pipeline)
			stomp_pipeline_r <= stomp_pipeline;
	end

	assign pe_stomp = advance_pipeline && stomp_pipeline && !stomp_pipeline_r;
	assign step1 = advance_pipeline || pe_stomp;
	assign step2 = advance_seg2 || pe_stomp;

	// a subroutine call with no known destination throws away the next group
	assign bsr_stomp = do_bsr && !found_destination;

	// ========================================================================
	// miss PC delay pipeline
	// ========================================================================

	// depth k holds the target that should show up k stages down the front
	// end, the reset value lets the flags drop as fetch starts at RESET_PC
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 5; i++) begin
				misspcr[i].bno_t <= 5'd1;
				misspcr[i].bno_f <= 5'd0;
				misspcr[i].pc <= `RESET_PC;
			end
		end else begin
			if (pe_stomp)
				misspcr[0] <= misspc;
			if (step1) begin
				for (int i = 1; i < 5; i++)
					misspcr[i] <= misspcr[i-1];
			end
		end
	end

	// ========================================================================
	// stage waterfall
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			aln_r <= 1'b1;
			fet_r <= 1'b1;
			mux_r <= 1'b1;
			dec_r <= 1'b1;
			bsr_mux <= 1'b0;
			bsr_dec <= 1'b0;
		end else if (step1) begin
			// the align stage has no predecessor and holds until the target is fetched
			aln_r <= next_flag(pe_stomp, pc.pc == misspcr[0].pc, aln_r);
			fet_r <= next_flag(pe_stomp, pc_f.pc == misspcr[1].pc, stomp_aln);
			mux_r <= next_flag(pe_stomp, pc_fet.pc == misspcr[2].pc, stomp_fet || bsr_stomp);
			dec_r <= next_flag(pe_stomp, pc_mux.pc == misspcr[3].pc, stomp_mux);
			bsr_mux <= bsr_stomp;
			bsr_dec <= bsr_mux;
		end
	end

	// rename and the queue belong to the second pipeline segment
	always_ff @(posedge clk) begin
		if (rst) begin
			ren_r <= 1'b1;
			que_r <= 1'b1;
			que2_r <= 1'b1;
			quem_r <= 1'b1;
			bsr_ren <= 1'b0;
			bsr_que <= 1'b0;
		end else if (step2) begin
			ren_r <= next_flag(pe_stomp, pc_dec.pc == misspcr[4].pc, stomp_dec);
			// renamed work is queued anyway and turned into copy targets
			que_r <= stomp_ren;
			que2_r <= que_r;
			quem_r <= stomp_ren || stomp_pipeline;
			bsr_ren <= bsr_dec;
			bsr_que <= bsr_ren;
		end
	end

	// the pulse stomps every stage in the cycle it occurs
	assign stomp_aln = pe_stomp || aln_r;
	assign stomp_fet = pe_stomp || fet_r;
	assign stomp_mux = pe_stomp || mux_r;
	assign stomp_dec = pe_stomp || dec_r;
	assign stomp_ren = pe_stomp || ren_r;
	assign stomp_quem = pe_stomp || quem_r;

	// behind a call the queue also stomps the group that follows
	assign stomp_que = pe_stomp || que_r || (bsr_que && que2_r);

endmodule

//--- rtl/branch_recovery_seq.sv
// Branch recovery sequencer

module branch_recovery_seq (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    branchmiss,
	input  logic                    found_destination,
	output pipe_pkg::branch_state_t branch_state
);

	pipe_pkg::branch_state_t state_next;

	// ========================================================================
	// fixed walk through the recovery states
	// ========================================================================

	// a miss whose target is already in the ROB needs no recovery, the
	// entries in between are simply stomped
	always_comb begin
		state_next = branch_state;
		case (branch_state)
			pipe_pkg::BS_IDLE: begin
				if (branchmiss && !found_destination)
					state_next = pipe_pkg::BS_CHKPT_RESTORE;
			end
			// the checkpoint of the register map is restored here
			pipe_pkg::BS_CHKPT_RESTORE: state_next = pipe_pkg::BS_STATE1;
			pipe_pkg::BS_STATE1:        state_next = pipe_pkg::BS_DONE1;
			pipe_pkg::BS_DONE1:         state_next = pipe_pkg::BS_DONE2;
			// last state, the front end is released after it
			pipe_pkg::BS_DONE2:         state_next = pipe_pkg::BS_IDLE;
			default:                    state_next = pipe_pkg::BS_IDLE;
		endcase
	end

	// one state per clock, back in idle five cycles after the miss
	always_ff @(posedge clk) begin
		if (rst)
			branch_state <= pipe_pkg::BS_IDLE;
		else
			branch_state <= state_next;
	end

endmodule

//--- rtl/rob_pkg.sv
// Reorder buffer types

`include "stomp_settings.svh"

package rob_pkg;

	// index of one reorder buffer entry
	typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_ndx_t;

	// ========================================================================
	// entry record
	// ========================================================================

	// sn orders the entries by age, a larger number is a younger entry
	// grp names the fetch group the instruction arrived in
	// bno_t is the branch number the entry was fetched under
	// br and cjb flag a conditional branch and a call or jump
	typedef struct packed {
		logic               valid;
		logic [`SN_BITS-1:0] sn;
		logic [3:0]         grp;
		logic [4:0]         bno_t;
		logic               br;
		logic               cjb;
	} rob_entry_t;

	// ========================================================================
	// dispatch write
	// ========================================================================

	// the store stamps its own serial number, so entry.sn is not looked at
	typedef struct packed {
		logic       wr;
		rob_ndx_t   ndx;
		rob_entry_t entry;
	} rob_write_t;

endpackage

//--- rtl/pipe_pkg.sv
// Front end pipeline types

package pipe_pkg;

	// ========================================================================
	// extended program counter
	// ========================================================================

	// the address travels with the branch numbers for both outcomes, so
	// that a stage can tell which branch path its fetch group belongs to
	typedef struct packed {
		logic [4:0]  bno_t;
		logic [4:0]  bno_f;
		logic [31:0] pc;
	} pc_address_ex_t;

	// ========================================================================
	// branch recovery sequencer state
	// ========================================================================

	// the states follow each other in this order, and the front end relies
	// on CHKPT_RESTORE through DONE2 being a contiguous range
	typedef enum logic [2:0] {
		BS_IDLE,
		BS_CHKPT_RESTORE,
		BS_STATE1,
		BS_DONE1,
		BS_DONE2
	} branch_state_t;

endpackage

//--- rtl/stomp_settings.svh
// Stomp subsystem settings

`ifndef STOMP_SETTINGS_SVH
`define STOMP_SETTINGS_SVH

// number of reorder buffer entries, a power of two
`define ROB_ENTRIES 8

// width of the serial number stamped on each dispatched entry
`define SN_BITS 8

// program counter the front end starts fetching from after reset
`define RESET_PC 32'h0000_0100

// set to 1 when the register mappings of a mispredicted group can be backed out
`define SUPPORT_BACKOUT 1

`endif
